// File: src/rvPkg.sv
/*
 * RV32 only. Instructions are one 32-bit word, so Xlen must stay 32.
 * Select encodings must match those of the external controller.
 */
package rvPkg;

    localparam int Xlen     = 32;
    localparam int RegAddrW = 5;

    localparam logic [Xlen-1:0] PcStart = '0;

    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpLui    = 7'b0110111;

    localparam logic [2:0] Funct3Beq = 3'b000;
    localparam logic [2:0] Funct3Bne = 3'b001;

    // addi x0,x0,0
    localparam logic [31:0] NopInstr = 32'h0000_0013;

    typedef enum logic [2:0] {
        ImmI = 3'd0,
        ImmS = 3'd1,
        ImmB = 3'd2,
        ImmJ = 3'd3,
        ImmU = 3'd4
    } immSrcT;

    typedef enum logic [1:0] {
        FwdReg = 2'b00,
        FwdWb  = 2'b01,
        FwdMem = 2'b10
    } forwardT;

    typedef enum logic [1:0] {
        ResMem     = 2'b00,
        ResAlu     = 2'b01,
        ResPcPlus4 = 2'b10,
        ResImm     = 2'b11
    } resultSrcT;

    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluAnd = 3'b010,
        AluOr  = 3'b011,
        AluSlt = 3'b101
    } aluCtrlT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormatT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormatT;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFormatT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFormatT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFormatT;

    typedef union packed {
        iFormatT iView;
        sFormatT sView;
        bFormatT bView;
        jFormatT jView;
        uFormatT uView;
    } instrWordT;

endpackage

// File: src/alu.sv
/*
 * Integer ALU: add, sub, and, or, signed slt.
 * Unused control codes give zero.
 */
`timescale 1ns/1ns

module alu #(
    parameter int Xlen = 32
) (
    input  logic [Xlen-1:0] a_i,
    input  logic [Xlen-1:0] b_i,
    input  rvPkg::aluCtrlT  aluControl_i,
    output logic [Xlen-1:0] result_o,
    output logic            zero_o
);

    always_comb begin
        case (aluControl_i)
            rvPkg::AluAdd: result_o = a_i + b_i;
            rvPkg::AluSub: result_o = a_i - b_i;
            rvPkg::AluAnd: result_o = a_i & b_i;
            rvPkg::AluOr:  result_o = a_i | b_i;
            // Signed compare, result in bit 0
            rvPkg::AluSlt: result_o = Xlen'($signed(a_i) < $signed(b_i));
            default:       result_o = '0;
        endcase
    end

    // Used by beq and bne in execute
    assign zero_o = (result_o == '0);

endmodule

// File: src/immExtend.sv
/*
 * Sign-extended immediate for the decode instruction.
 * An unknown format gives zero.
 */
`timescale 1ns/1ns

module immExtend #(
    parameter int Xlen = 32
) (
    input  rvPkg::instrWordT InstrD_i,
    input  rvPkg::immSrcT    ImmSrcD_i,
    output logic [Xlen-1:0]  ExtImmD_o
);

    // Each format is built as a signed value and then widened to Xlen
    always_comb begin
        case (ImmSrcD_i)
            rvPkg::ImmI: ExtImmD_o = Xlen'($signed(InstrD_i.iView.imm));
            rvPkg::ImmS: ExtImmD_o = Xlen'($signed({InstrD_i.sView.immHi,
                                                    InstrD_i.sView.immLo}));
            rvPkg::ImmB: ExtImmD_o = Xlen'($signed({InstrD_i.bView.imm12,
                                                    InstrD_i.bView.imm11,
                                                    InstrD_i.bView.imm10to5,
                                                    InstrD_i.bView.imm4to1,
                                                    1'b0}));
            rvPkg::ImmJ: ExtImmD_o = Xlen'($signed({InstrD_i.jView.imm20,
                                                    InstrD_i.jView.imm19to12,
                                                    InstrD_i.jView.imm11,
                                                    InstrD_i.jView.imm10to1,
                                                    1'b0}));
            // Upper 20 bits, low 12 cleared
            rvPkg::ImmU: ExtImmD_o = Xlen'($signed({InstrD_i.uView.imm, 12'b0}));
            default:     ExtImmD_o = '0;
        endcase
    end

endmodule

// File: src/regFile.sv
/*
 * Register file, two reads and one write on clk, x0 reads as zero.
 * A read of the register being written returns the write data.
 */
`timescale 1ns/1ns

module regFile #(
    parameter int Xlen     = 32,
    parameter int RegAddrW = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [RegAddrW-1:0] Rs1_i,
    input  logic [RegAddrW-1:0] Rs2_i,
    input  logic [RegAddrW-1:0] Rd_i,
    input  logic                We_i,
    input  logic [Xlen-1:0]     Wd_i,
    output logic [Xlen-1:0]     Rd1_o,
    output logic [Xlen-1:0]     Rd2_o
);

    // x0 has no storage
    logic [Xlen-1:0] regs [1:(2**RegAddrW)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 2**RegAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (We_i && (Rd_i != '0)) begin
            regs[Rd_i] <= Wd_i;
        end
    end

    function automatic logic [Xlen-1:0] readReg(input logic [RegAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (We_i && (addr == Rd_i)) begin
            // Bypass the write of this cycle
            return Wd_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        Rd1_o = readReg(Rs1_i);
        Rd2_o = readReg(Rs2_i);
    end

endmodule

// File: src/fetchDecode.sv
/*
 * PC register and decode register. Fetch is sequential unless execute redirects.
 * Flush loads a NOP into decode. Stall holds the PC or the decode register.
 */
`timescale 1ns/1ns

module fetchDecode #(
    parameter int              Xlen     = 32,
    parameter int              RegAddrW = 5,
    parameter logic [Xlen-1:0] PcStart  = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                StallF_i,
    input  logic                StallD_i,
    input  logic                FlushD_i,
    input  rvPkg::instrWordT    InstrF_i,
    input  logic                Mispredict_i,
    input  logic [Xlen-1:0]     PCTargetE_i,
    output logic [Xlen-1:0]     PCF_o,
    output rvPkg::instrWordT    InstrD_o,
    output logic [Xlen-1:0]     PCD_o,
    output logic [Xlen-1:0]     PCPlus4D_o,
    output logic [6:0]          op_o,
    output logic [2:0]          funct3_o,
    output logic                funct7b5_o,
    output logic [RegAddrW-1:0] Rs1D_o,
    output logic [RegAddrW-1:0] Rs2D_o,
    output logic [RegAddrW-1:0] RdD_o
);

    logic [Xlen-1:0] pcPlus4F;

    assign pcPlus4F = PCF_o + Xlen'(4);

    // Branches are predicted not taken, so only execute can redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            PCF_o <= PcStart;
        end else if (!StallF_i) begin
            PCF_o <= Mispredict_i ? PCTargetE_i : pcPlus4F;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || FlushD_i) begin
            InstrD_o   <= rvPkg::NopInstr;
            PCD_o      <= '0;
            PCPlus4D_o <= '0;
        end else if (!StallD_i) begin
            InstrD_o   <= InstrF_i;
            PCD_o      <= PCF_o;
            PCPlus4D_o <= pcPlus4F;
        end
    end

    // Fields for the controller and the register file
    assign op_o     = InstrD_o.iView.opcode;
    assign funct3_o = InstrD_o.iView.funct3;
    assign Rs1D_o   = InstrD_o.iView.rs1;
    assign RdD_o    = InstrD_o.iView.rd;
    assign Rs2D_o   = InstrD_o.sView.rs2;
    // funct7 bit 5 sits in the S upper immediate field
    assign funct7b5_o = InstrD_o.sView.immHi[5];

endmodule

// File: src/executeStage.sv
/*
 * Execute register, operand forwarding, ALU and branch resolution.
 * Only beq, bne and jal redirect. Flush clears the stage to a bubble.
 */
`timescale 1ns/1ns

module executeStage #(
    parameter int Xlen     = 32,
    parameter int RegAddrW = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                FlushE_i,
    input  logic [Xlen-1:0]     Rd1D_i,
    input  logic [Xlen-1:0]     Rd2D_i,
    input  logic [Xlen-1:0]     PCD_i,
    input  logic [Xlen-1:0]     PCPlus4D_i,
    input  logic [Xlen-1:0]     ExtImmD_i,
    input  logic [6:0]          op_i,
    input  logic [2:0]          funct3_i,
    input  logic [RegAddrW-1:0] Rs1D_i,
    input  logic [RegAddrW-1:0] Rs2D_i,
    input  logic [RegAddrW-1:0] RdD_i,
    input  logic                ALUSrcE_i,
    input  rvPkg::aluCtrlT      ALUControlE_i,
    input  rvPkg::forwardT      ForwardAE_i,
    input  rvPkg::forwardT      ForwardBE_i,
    input  logic [Xlen-1:0]     ForwardDataM_i,
    input  logic [Xlen-1:0]     ResultW_i,
    output logic [RegAddrW-1:0] Rs1E_o,
    output logic [RegAddrW-1:0] Rs2E_o,
    output logic [RegAddrW-1:0] RdE_o,
    output logic [Xlen-1:0]     ALUResultE_o,
    output logic [Xlen-1:0]     WriteDataE_o,
    output logic [Xlen-1:0]     ExtImmE_o,
    output logic [Xlen-1:0]     PCPlus4E_o,
    output logic [Xlen-1:0]     PCTargetE_o,
    output logic                ZeroE_o,
    output logic                Mispredict_o
);

    logic [Xlen-1:0] rd1E;
    logic [Xlen-1:0] rd2E;
    logic [Xlen-1:0] pcE;
    logic [6:0]      opE;
    logic [2:0]      funct3E;
    logic [Xlen-1:0] srcAE;
    logic [Xlen-1:0] srcBE;
    logic            branchTakenE;

    always_ff @(posedge clk) begin
        if (reset || FlushE_i) begin
            rd1E       <= '0;
            rd2E       <= '0;
            pcE        <= '0;
            PCPlus4E_o <= '0;
            ExtImmE_o  <= '0;
            opE        <= '0;
            funct3E    <= '0;
            Rs1E_o     <= '0;
            Rs2E_o     <= '0;
            RdE_o      <= '0;
        end else begin
            rd1E       <= Rd1D_i;
            rd2E       <= Rd2D_i;
            pcE        <= PCD_i;
            PCPlus4E_o <= PCPlus4D_i;
            ExtImmE_o  <= ExtImmD_i;
            opE        <= op_i;
            funct3E    <= funct3_i;
            Rs1E_o     <= Rs1D_i;
            Rs2E_o     <= Rs2D_i;
            RdE_o      <= RdD_i;
        end
    end

    // Same selection for both operands
    function automatic logic [Xlen-1:0] pickOperand(
        input rvPkg::forwardT  sel,
        input logic [Xlen-1:0] regVal,
        input logic [Xlen-1:0] wbVal,
        input logic [Xlen-1:0] memVal
    );
        case (sel)
            rvPkg::FwdWb:  return wbVal;
            rvPkg::FwdMem: return memVal;
            default:       return regVal;
        endcase
    endfunction

    assign srcAE        = pickOperand(ForwardAE_i, rd1E, ResultW_i, ForwardDataM_i);
    assign WriteDataE_o = pickOperand(ForwardBE_i, rd2E, ResultW_i, ForwardDataM_i);
    assign srcBE        = ALUSrcE_i ? ExtImmE_o : WriteDataE_o;

    alu #(
        .Xlen(Xlen)
    ) alu_i (
        .a_i         (srcAE),
        .b_i         (srcBE),
        .aluControl_i(ALUControlE_i),
        .result_o    (ALUResultE_o),
        .zero_o      (ZeroE_o)
    );

    // The controller sets AluSub for branches, so zero means equal
    assign branchTakenE = (opE == rvPkg::OpBranch) &&
                          (((funct3E == rvPkg::Funct3Beq) && ZeroE_o) ||
                           ((funct3E == rvPkg::Funct3Bne) && !ZeroE_o));

    // Predicted not taken, so every taken branch or jump mispredicts
    assign Mispredict_o = branchTakenE || (opE == rvPkg::OpJal);
    assign PCTargetE_o  = pcE + ExtImmE_o;

endmodule

// File: src/memWriteback.sv
/*
 * Memory and writeback registers with their result selects.
 * Memory data is read combinationally outside and arrives on ReadDataM_i.
 */
`timescale 1ns/1ns

module memWriteback #(
    parameter int Xlen     = 32,
    parameter int RegAddrW = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [Xlen-1:0]     ALUResultE_i,
    input  logic [Xlen-1:0]     WriteDataE_i,
    input  logic [Xlen-1:0]     ExtImmE_i,
    input  logic [Xlen-1:0]     PCPlus4E_i,
    input  logic [RegAddrW-1:0] RdE_i,
    input  rvPkg::resultSrcT    ResultSrcM_i,
    input  rvPkg::resultSrcT    ResultSrcW_i,
    input  logic [Xlen-1:0]     ReadDataM_i,
    output logic [Xlen-1:0]     ALUResultM_o,
    output logic [Xlen-1:0]     WriteDataM_o,
    output logic [RegAddrW-1:0] RdM_o,
    output logic [Xlen-1:0]     ForwardDataM_o,
    output logic [Xlen-1:0]     ResultW_o,
    output logic [RegAddrW-1:0] RdW_o
);

    logic [Xlen-1:0] extImmM;
    logic [Xlen-1:0] pcPlus4M;
    logic [Xlen-1:0] aluResultW;
    logic [Xlen-1:0] readDataW;
    logic [Xlen-1:0] extImmW;
    logic [Xlen-1:0] pcPlus4W;

    always_ff @(posedge clk) begin
        if (reset) begin
            ALUResultM_o <= '0;
            RdM_o        <= '0;
            RdW_o        <= '0;
        end else begin
            ALUResultM_o <= ALUResultE_i;
            RdM_o        <= RdE_i;
            RdW_o        <= RdM_o;
        end
    end

    always_ff @(posedge clk) begin
        WriteDataM_o <= WriteDataE_i;
        extImmM      <= ExtImmE_i;
        pcPlus4M     <= PCPlus4E_i;
        aluResultW   <= ALUResultM_o;
        readDataW    <= ReadDataM_i;
        extImmW      <= extImmM;
        pcPlus4W     <= pcPlus4M;
    end

    // Load data is not ready here, so a load cannot forward from memory
    always_comb begin
        case (ResultSrcM_i)
            rvPkg::ResAlu:     ForwardDataM_o = ALUResultM_o;
            rvPkg::ResPcPlus4: ForwardDataM_o = pcPlus4M;
            rvPkg::ResImm:     ForwardDataM_o = extImmM;
            default:           ForwardDataM_o = '0;
        endcase
    end

    always_comb begin
        case (ResultSrcW_i)
            rvPkg::ResMem:     ResultW_o = readDataW;
            rvPkg::ResAlu:     ResultW_o = aluResultW;
            rvPkg::ResPcPlus4: ResultW_o = pcPlus4W;
            default:           ResultW_o = extImmW;
        endcase
    end

endmodule

// File: src/pipelineDatapath.sv
/*
 * Five-stage RV32 datapath. Controller and hazard unit are external.
 * Execute and later stages never stall, so flush execute while decode stalls.
 */
`timescale 1ns/1ns

module pipelineDatapath #(
    parameter int              Xlen     = rvPkg::Xlen,
    parameter int              RegAddrW = rvPkg::RegAddrW,
    parameter logic [Xlen-1:0] PcStart  = rvPkg::PcStart
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                StallF_i,
    input  logic                StallD_i,
    input  logic                FlushD_i,
    input  logic                FlushE_i,
    input  logic [Xlen-1:0]     InstrF_i,
    input  rvPkg::immSrcT       ImmSrcD_i,
    input  logic                RegWriteW_i,
    input  logic                ALUSrcE_i,
    input  rvPkg::aluCtrlT      ALUControlE_i,
    input  rvPkg::forwardT      ForwardAE_i,
    input  rvPkg::forwardT      ForwardBE_i,
    input  rvPkg::resultSrcT    ResultSrcM_i,
    input  rvPkg::resultSrcT    ResultSrcW_i,
    input  logic [Xlen-1:0]     ReadDataM_i,
    output logic [Xlen-1:0]     PCF_o,
    output logic [6:0]          op_o,
    output logic [2:0]          funct3_o,
    output logic                funct7b5_o,
    output logic [RegAddrW-1:0] Rs1D_o,
    output logic [RegAddrW-1:0] Rs2D_o,
    output logic [RegAddrW-1:0] RdD_o,
    output logic [RegAddrW-1:0] Rs1E_o,
    output logic [RegAddrW-1:0] Rs2E_o,
    output logic [RegAddrW-1:0] RdE_o,
    output logic                ZeroE_o,
    output logic                Mispredict_o,
    output logic [RegAddrW-1:0] RdM_o,
    output logic [Xlen-1:0]     ALUResultM_o,
    output logic [Xlen-1:0]     WriteDataM_o,
    output logic [RegAddrW-1:0] RdW_o
);

    rvPkg::instrWordT instrD;
    logic [Xlen-1:0]  pcD;
    logic [Xlen-1:0]  pcPlus4D;
    logic [Xlen-1:0]  rd1D;
    logic [Xlen-1:0]  rd2D;
    logic [Xlen-1:0]  extImmD;
    logic [Xlen-1:0]  aluResultE;
    logic [Xlen-1:0]  writeDataE;
    logic [Xlen-1:0]  extImmE;
    logic [Xlen-1:0]  pcPlus4E;
    logic [Xlen-1:0]  pcTargetE;
    logic [Xlen-1:0]  forwardDataM;
    logic [Xlen-1:0]  resultW;

    fetchDecode #(
        .Xlen    (Xlen),
        .RegAddrW(RegAddrW),
        .PcStart (PcStart)
    ) fetchDecode_i (
        .clk         (clk),
        .reset       (reset),
        .StallF_i    (StallF_i),
        .StallD_i    (StallD_i),
        .FlushD_i    (FlushD_i),
        .InstrF_i    (InstrF_i),
        .Mispredict_i(Mispredict_o),
        .PCTargetE_i (pcTargetE),
        .PCF_o       (PCF_o),
        .InstrD_o    (instrD),
        .PCD_o       (pcD),
        .PCPlus4D_o  (pcPlus4D),
        .op_o        (op_o),
        .funct3_o    (funct3_o),
        .funct7b5_o  (funct7b5_o),
        .Rs1D_o      (Rs1D_o),
        .Rs2D_o      (Rs2D_o),
        .RdD_o       (RdD_o)
    );

    // Written from writeback, read in decode
    regFile #(
        .Xlen    (Xlen),
        .RegAddrW(RegAddrW)
    ) regFile_i (
        .clk  (clk),
        .reset(reset),
        .Rs1_i(Rs1D_o),
        .Rs2_i(Rs2D_o),
        .Rd_i (RdW_o),
        .We_i (RegWriteW_i),
        .Wd_i (resultW),
        .Rd1_o(rd1D),
        .Rd2_o(rd2D)
    );

    immExtend #(
        .Xlen(Xlen)
    ) immExtend_i (
        .InstrD_i (instrD),
        .ImmSrcD_i(ImmSrcD_i),
        .ExtImmD_o(extImmD)
    );

    executeStage #(
        .Xlen    (Xlen),
        .RegAddrW(RegAddrW)
    ) executeStage_i (
        .clk           (clk),
        .reset         (reset),
        .FlushE_i      (FlushE_i),
        .Rd1D_i        (rd1D),
        .Rd2D_i        (rd2D),
        .PCD_i         (pcD),
        .PCPlus4D_i    (pcPlus4D),
        .ExtImmD_i     (extImmD),
        .op_i          (op_o),
        .funct3_i      (funct3_o),
        .Rs1D_i        (Rs1D_o),
        .Rs2D_i        (Rs2D_o),
        .RdD_i         (RdD_o),
        .ALUSrcE_i     (ALUSrcE_i),
        .ALUControlE_i (ALUControlE_i),
        .ForwardAE_i   (ForwardAE_i),
        .ForwardBE_i   (ForwardBE_i),
        .ForwardDataM_i(forwardDataM),
        .ResultW_i     (resultW),
        .Rs1E_o        (Rs1E_o),
        .Rs2E_o        (Rs2E_o),
        .RdE_o         (RdE_o),
        .ALUResultE_o  (aluResultE),
        .WriteDataE_o  (writeDataE),
        .ExtImmE_o     (extImmE),
        .PCPlus4E_o    (pcPlus4E),
        .PCTargetE_o   (pcTargetE),
        .ZeroE_o       (ZeroE_o),
        .Mispredict_o  (Mispredict_o)
    );

    memWriteback #(
        .Xlen    (Xlen),
        .RegAddrW(RegAddrW)
    ) memWriteback_i (
        .clk           (clk),
        .reset         (reset),
        .ALUResultE_i  (aluResultE),
        .WriteDataE_i  (writeDataE),
        .ExtImmE_i     (extImmE),
        .PCPlus4E_i    (pcPlus4E),
        .RdE_i         (RdE_o),
        .ResultSrcM_i  (ResultSrcM_i),
        .ResultSrcW_i  (ResultSrcW_i),
        .ReadDataM_i   (ReadDataM_i),
        .ALUResultM_o  (ALUResultM_o),
        .WriteDataM_o  (WriteDataM_o),
        .RdM_o         (RdM_o),
        .ForwardDataM_o(forwardDataM),
        .ResultW_o     (resultW),
        .RdW_o         (RdW_o)
    );

endmodule

// File: test/stimulusTable.svh
/*
 * Rows apply one per cycle, the first on the edge that releases reset.
 * Expected values describe the state visible while the row is driven.
 */

// Columns: instr, immSrc, aluCtl, aluSrc, fwdA, fwdB, resM, resW,
//   flags {stallF,stallD,flushD,flushE,regWrite}, readDataM,
//   mask {pc,dec,aluM,misp,rdW}, expPc, expDec, expAluM, expMisp, expRdW
// Encodings: imm I0 S1 B2 J3 U4, alu add0 sub1, fwd reg0 wb1 mem2,
//   result mem0 alu1 pc4 2 imm3
task automatic fillTable();
    // addi x5,x0,100 then forwarding from memory and register bypass
    addRow(32'h06400293, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 0, 0, 0, 0, 0);
    addRow(32'h00528333, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b11000, 4, 32'h06400293, 0, 0, 0);
    addRow(32'h00000013, 0, 0, 1, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 8, 0, 0, 0, 0);
    addRow(32'h005283B3, 0, 0, 0, 2, 2, 1, 0, 5'b00000, 0, 5'b10100, 12, 0, 100, 0, 0);
    addRow(32'h00000013, 0, 0, 1, 0, 0, 1, 1, 5'b00001, 0,
           5'b01101, 0, 32'h005283B3, 200, 0, 5);
    addRow(32'h00000013, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 20, 0, 0, 0, 0);
    addRow(32'h00002403, 0, 0, 0, 0, 0, 1, 0, 5'b00000, 0, 5'b00100, 0, 0, 200, 0, 0);
    // lw x8 then add x9,x8,x8 forwarded from writeback
    addRow(32'h00000013, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b01000, 0, 32'h00002403, 0, 0, 0);
    addRow(32'h008404B3, 0, 0, 1, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 32, 0, 0, 0, 0);
    addRow(32'h00000013, 0, 0, 1, 0, 0, 0, 0, 5'b00000, 32'hCAFE0001,
           5'b00100, 0, 0, 0, 0, 0);
    addRow(32'h00000013, 0, 0, 0, 1, 1, 0, 0, 5'b00001, 0, 5'b00001, 0, 0, 0, 0, 8);
    // Stall fetch and decode for one cycle
    addRow(32'h00000013, 0, 0, 0, 0, 0, 1, 0, 5'b11010, 0,
           5'b10100, 44, 0, 32'h95FC0002, 0, 0);
    addRow(32'h00000013, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 44, 0, 0, 0, 0);
    // beq x0,x0,+16 taken
    addRow(32'h00000863, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 48, 0, 0, 0, 0);
    addRow(32'h005283B3, 2, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b11000, 52, 32'h00000863, 0, 0, 0);
    addRow(32'h00528333, 0, 1, 0, 0, 0, 0, 0, 5'b00110, 0, 5'b10010, 56, 0, 0, 1, 0);
    // jal x1,+32 at the branch target
    addRow(32'h020000EF, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b11010, 64, 32'h00000013, 0, 0, 0);
    addRow(32'h00000013, 3, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b01000, 0, 32'h020000EF, 0, 0, 0);
    addRow(32'h00000013, 0, 0, 0, 0, 0, 0, 0, 5'b00110, 0, 5'b10010, 72, 0, 0, 1, 0);
    // bne x0,x0 never taken
    addRow(32'h00001863, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10010, 96, 0, 0, 0, 0);
    addRow(32'h00000013, 2, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b00000, 0, 0, 0, 0, 0);
    addRow(32'h00000013, 0, 1, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10010, 104, 0, 0, 0, 0);
    addRow(32'h00000013, 0, 0, 0, 0, 0, 0, 0, 5'b00000, 0, 5'b10000, 108, 0, 0, 0, 0);
endtask

// File: test/datapathTb.sv
/*
 * Table-driven testbench for the datapath, with the controller's role played by the rows.
 * Stops at the first mismatch.
 */
`timescale 1ns/1ns

module datapathTb;

    localparam int MaxRows    = 64;
    localparam int RandCount  = 20;
    localparam int MaxCycles  = 2000;

    typedef struct packed {
        logic [31:0] instr;
        logic [2:0]  imm;
        logic [2:0]  alu;
        logic        aluSrc;
        logic [1:0]  fwdA;
        logic [1:0]  fwdB;
        logic [1:0]  resM;
        logic [1:0]  resW;
        logic [4:0]  flags;
        logic [31:0] rdData;
        logic [4:0]  mask;
        logic [31:0] expPc;
        logic [31:0] expDec;
        logic [31:0] expAluM;
        logic        expMisp;
        logic [4:0]  expRdW;
    } rowT;

    logic clk = 1'b0;
    logic reset;
    logic StallF_i;
    logic StallD_i;
    logic FlushD_i;
    logic FlushE_i;
    logic [31:0] InstrF_i;
    rvPkg::immSrcT ImmSrcD_i;
    logic RegWriteW_i;
    logic ALUSrcE_i;
    rvPkg::aluCtrlT ALUControlE_i;
    rvPkg::forwardT ForwardAE_i;
    rvPkg::forwardT ForwardBE_i;
    rvPkg::resultSrcT ResultSrcM_i;
    rvPkg::resultSrcT ResultSrcW_i;
    logic [31:0] ReadDataM_i;
    logic [31:0] PCF_o;
    logic [6:0] op_o;
    logic [2:0] funct3_o;
    logic funct7b5_o;
    logic [4:0] Rs1D_o;
    logic [4:0] Rs2D_o;
    logic [4:0] RdD_o;
    logic [4:0] Rs1E_o;
    logic [4:0] Rs2E_o;
    logic [4:0] RdE_o;
    logic ZeroE_o;
    logic Mispredict_o;
    logic [4:0] RdM_o;
    logic [31:0] ALUResultM_o;
    logic [31:0] WriteDataM_o;
    logic [4:0] RdW_o;

    rowT rows [MaxRows];
    int  rowCount = 0;
    logic [31:0] rndInstr [RandCount];
    logic [2:0]  rndFmt [RandCount];

    always #2 clk = ~clk;

    pipelineDatapath pipelineDatapath_i (
        .clk(clk), .reset(reset), .StallF_i(StallF_i), .StallD_i(StallD_i),
        .FlushD_i(FlushD_i), .FlushE_i(FlushE_i), .InstrF_i(InstrF_i),
        .ImmSrcD_i(ImmSrcD_i), .RegWriteW_i(RegWriteW_i), .ALUSrcE_i(ALUSrcE_i),
        .ALUControlE_i(ALUControlE_i), .ForwardAE_i(ForwardAE_i),
        .ForwardBE_i(ForwardBE_i), .ResultSrcM_i(ResultSrcM_i),
        .ResultSrcW_i(ResultSrcW_i), .ReadDataM_i(ReadDataM_i), .PCF_o(PCF_o),
        .op_o(op_o), .funct3_o(funct3_o), .funct7b5_o(funct7b5_o), .Rs1D_o(Rs1D_o),
        .Rs2D_o(Rs2D_o), .RdD_o(RdD_o), .Rs1E_o(Rs1E_o), .Rs2E_o(Rs2E_o),
        .RdE_o(RdE_o), .ZeroE_o(ZeroE_o), .Mispredict_o(Mispredict_o), .RdM_o(RdM_o),
        .ALUResultM_o(ALUResultM_o), .WriteDataM_o(WriteDataM_o), .RdW_o(RdW_o)
    );

    task automatic addRow(input logic [31:0] instr, input logic [2:0] imm,
                          input logic [2:0] alu, input logic aluSrc,
                          input logic [1:0] fwdA, input logic [1:0] fwdB,
                          input logic [1:0] resM, input logic [1:0] resW,
                          input logic [4:0] flags, input logic [31:0] rdData,
                          input logic [4:0] mask, input logic [31:0] expPc,
                          input logic [31:0] expDec, input logic [31:0] expAluM,
                          input logic expMisp, input logic [4:0] expRdW);
        rows[rowCount] = {instr, imm, alu, aluSrc, fwdA, fwdB, resM, resW, flags,
                          rdData, mask, expPc, expDec, expAluM, expMisp, expRdW};
        rowCount++;
    endtask

    `include "stimulusTable.svh"

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual,
                     expected);
            $display("*** FAILED ***");
            $fatal(1, "Check failed");
        end
    endtask

    // Immediate rules of the RV32I formats
    function automatic logic [31:0] formatImmediate(input logic [31:0] i,
                                                    input logic [2:0] fmt);
        case (fmt)
            3'd0: return {{20{i[31]}}, i[31:20]};
            3'd1: return {{20{i[31]}}, i[31:25], i[11:7]};
            3'd2: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            3'd3: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            3'd4: return {i[31:12], 12'b0};
            default: return 32'd0;
        endcase
    endfunction

    // Returns on the edge that releases reset
    task automatic resetDut();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic applyRow(input rowT r);
        InstrF_i      <= r.instr;
        ImmSrcD_i     <= rvPkg::immSrcT'(r.imm);
        ALUControlE_i <= rvPkg::aluCtrlT'(r.alu);
        ALUSrcE_i     <= r.aluSrc;
        ForwardAE_i   <= rvPkg::forwardT'(r.fwdA);
        ForwardBE_i   <= rvPkg::forwardT'(r.fwdB);
        ResultSrcM_i  <= rvPkg::resultSrcT'(r.resM);
        ResultSrcW_i  <= rvPkg::resultSrcT'(r.resW);
        {StallF_i, StallD_i, FlushD_i, FlushE_i, RegWriteW_i} <= r.flags;
        ReadDataM_i   <= r.rdData;
    endtask

    task automatic checkRow(input rowT r);
        if (r.mask[4]) checkValue("PCF_o", PCF_o, r.expPc);
        if (r.mask[3]) begin
            checkValue("op_o", op_o, r.expDec[6:0]);
            checkValue("funct3_o", funct3_o, r.expDec[14:12]);
            checkValue("funct7b5_o", funct7b5_o, r.expDec[30]);
            checkValue("Rs1D_o", Rs1D_o, r.expDec[19:15]);
            checkValue("Rs2D_o", Rs2D_o, r.expDec[24:20]);
            checkValue("RdD_o", RdD_o, r.expDec[11:7]);
        end
        if (r.mask[2]) checkValue("ALUResultM_o", ALUResultM_o, r.expAluM);
        if (r.mask[1]) checkValue("Mispredict_o", Mispredict_o, r.expMisp);
        if (r.mask[0]) checkValue("RdW_o", RdW_o, r.expRdW);
    endtask

    initial begin
        repeat (MaxCycles) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", MaxCycles);
        $display("*** FAILED ***");
        $fatal(1, "Timeout");
    end

    initial begin
        rowT r;
        logic [31:0] word;
        void'($urandom(61778));
        reset <= 1'b1;
        applyRow('0);
        InstrF_i <= rvPkg::NopInstr;
        fillTable();

        resetDut();
        checkValue("PCF_o", PCF_o, rvPkg::PcStart);
        for (int k = 0; k < rowCount; k++) begin
            applyRow(rows[k]);
            @(negedge clk);
            checkRow(rows[k]);
            @(posedge clk);
        end

        // Random immediates added to a register that reset clears
        for (int c = 0; c < RandCount; c++) begin
            word = $urandom();
            // A zero immediate lets the zero flag be seen high
            if (c == 0) word[31:20] = '0;
            rndInstr[c] = {word[31:7], rvPkg::OpImm};
            rndFmt[c] = 3'(c % 5);
        end
        resetDut();
        for (int c = 0; c < RandCount + 3; c++) begin
            r = '0;
            r.instr = (c < RandCount) ? rndInstr[c] : rvPkg::NopInstr;
            if (c >= 1 && c <= RandCount) r.imm = rndFmt[c-1];
            r.aluSrc = 1'b1;
            // Operand B takes the memory-stage ALU result on to WriteDataM_o
            r.fwdB = rvPkg::FwdMem;
            r.resM = rvPkg::ResAlu;
            applyRow(r);
            @(negedge clk);
            if (c >= 1 && c <= RandCount) begin
                checkValue("funct7b5_o", funct7b5_o, rndInstr[c-1][30]);
            end
            if (c >= 2 && c < RandCount + 2) begin
                checkValue("Rs1E_o", Rs1E_o, rndInstr[c-2][19:15]);
                checkValue("Rs2E_o", Rs2E_o, rndInstr[c-2][24:20]);
                checkValue("RdE_o", RdE_o, rndInstr[c-2][11:7]);
                checkValue("ZeroE_o", ZeroE_o,
                           formatImmediate(rndInstr[c-2], rndFmt[c-2]) == '0);
            end
            if (c >= 3) begin
                checkValue("ALUResultM_o", ALUResultM_o,
                           formatImmediate(rndInstr[c-3], rndFmt[c-3]));
                checkValue("RdM_o", RdM_o, rndInstr[c-3][11:7]);
            end
            if (c >= 4) begin
                checkValue("WriteDataM_o", WriteDataM_o,
                           formatImmediate(rndInstr[c-4], rndFmt[c-4]));
            end
            @(posedge clk);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: src.f
src/rvPkg.sv
src/alu.sv
src/immExtend.sv
src/regFile.sv
src/fetchDecode.sv
src/executeStage.sv
src/memWriteback.sv
src/pipelineDatapath.sv
+incdir+test
test/datapathTb.sv
